/* include/fpadd_settings.svh */
// Floating-point adder settings
`ifndef FPADD_SETTINGS_SVH
`define FPADD_SETTINGS_SVH

// Operand and field widths
`define FPADD_WIDTH 32
`define FPADD_EXP_W 8
`define FPADD_MAN_W 23

// Exponent bias and the saturated exponent
`define FPADD_EXP_BIAS 127
`define FPADD_EXP_MAX 255

// Output credits held after reset
`define FPADD_CREDITS 4

`endif

/* source/fpaddPkg.sv */
// Floating-point adder types

package fpaddPkg;

    // Operation select
    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOpE;

    // Controller states
    typedef enum logic [1:0]
    {
        sIdle = 2'd0,
        sEmit = 2'd1,
        sHold = 2'd2
    } ctrlStateE;

endpackage

/* source/fpBus.sv */
// Align to normalize stage bus

`timescale 1ns/1ps
`include "fpadd_settings.svh"

interface fpBus;
    // Aligned fields, hidden bit included
    logic [`FPADD_MAN_W:0]   alignedResult;
    logic                    carryOut;
    logic [`FPADD_EXP_W-1:0] exponentOut;
    logic                    alignedSign;
    logic                    guardBit;
    logic                    roundBit;
    logic                    stickyBit;

    // Normalized and rounded fields
    logic                    normalizedSign;
    logic [`FPADD_EXP_W-1:0] normalizedExponent;
    logic [`FPADD_MAN_W-1:0] normalizedMantissa;

    modport align (
        output alignedResult, carryOut, exponentOut, alignedSign,
        output guardBit, roundBit, stickyBit
    );

    modport normal (
        input  alignedResult, carryOut, exponentOut, alignedSign,
        input  guardBit, roundBit, stickyBit,
        output normalizedSign, normalizedExponent, normalizedMantissa
    );

    modport result (
        input  normalizedSign, normalizedExponent, normalizedMantissa
    );
endinterface

/* source/fpAlign.sv */
// Operand align and mantissa add

`timescale 1ns/1ps
`include "fpadd_settings.svh"

module fpAlign
    import fpaddPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    alignLoad,
    input  fpOpE                    opCode,
    input  logic [`FPADD_WIDTH-1:0] operandA,
    input  logic [`FPADD_WIDTH-1:0] operandB,
    fpBus.align                     bus
);
    localparam int manW  = `FPADD_MAN_W + 1;
    localparam int extW  = manW + 3;
    localparam int wideW = 2 * manW + 3;

    logic [`FPADD_EXP_W-1:0] expA, expB, expBig, expSmall, expDiff;
    logic [manW-1:0]         manA, manB, manBig, manSmall;
    logic                    signA, signB, signBig;
    logic                    aIsBig, effSub;
    logic [wideW-1:0]        wideSmall;
    logic [extW-1:0]         extBig, extSmall, extDiff;
    logic [extW:0]           extSum;

    // Unpack, exponent zero counts as a zero operand
    assign expA  = operandA[`FPADD_WIDTH-2 -: `FPADD_EXP_W];
    assign expB  = operandB[`FPADD_WIDTH-2 -: `FPADD_EXP_W];
    assign manA  = (expA != '0) ? {1'b1, operandA[`FPADD_MAN_W-1:0]} : '0;
    assign manB  = (expB != '0) ? {1'b1, operandB[`FPADD_MAN_W-1:0]} : '0;
    assign signA = operandA[`FPADD_WIDTH-1];
    assign signB = operandB[`FPADD_WIDTH-1] ^ (opCode == opSub);

    // Larger magnitude goes first
    assign aIsBig   = {expA, manA} >= {expB, manB};
    assign expBig   = aIsBig ? expA : expB;
    assign expSmall = aIsBig ? expB : expA;
    assign manBig   = aIsBig ? manA : manB;
    assign manSmall = aIsBig ? manB : manA;
    assign signBig  = aIsBig ? signA : signB;
    assign expDiff  = expBig - expSmall;
    assign effSub   = signA ^ signB;

    // Right shift with guard, round and sticky
    always_comb
    begin
        wideSmall = {manSmall, {(wideW - manW){1'b0}}} >> expDiff;
        if (expDiff >= `FPADD_EXP_W'(extW - 1))
            extSmall = {{(extW - 1){1'b0}}, |manSmall};
        else
            extSmall = {wideSmall[wideW-1 -: extW-1], |wideSmall[wideW-extW:0]};
    end

    assign extBig  = {manBig, 3'b000};
    assign extSum  = {1'b0, extBig} + {1'b0, extSmall};
    assign extDiff = extBig - extSmall;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            bus.alignedResult <= '0;
            bus.carryOut      <= 1'b0;
            bus.exponentOut   <= '0;
            bus.alignedSign   <= 1'b0;
            bus.guardBit      <= 1'b0;
            bus.roundBit      <= 1'b0;
            bus.stickyBit     <= 1'b0;
        end
        else if (alignLoad)
        begin
            bus.exponentOut <= expBig;
            bus.alignedSign <= signBig;
            if (effSub)
            begin
                // Larger minus smaller never borrows
                bus.carryOut <= 1'b0;
                {bus.alignedResult, bus.guardBit, bus.roundBit, bus.stickyBit} <= extDiff;
            end
            else
            begin
                {bus.carryOut, bus.alignedResult, bus.guardBit, bus.roundBit,
                 bus.stickyBit} <= extSum;
            end
        end
    end

    // Result exponent starts from the larger input exponent
    assert property (@(posedge clk) disable iff (!rstN)
        alignLoad |=> (bus.exponentOut >= $past(expA)) && (bus.exponentOut >= $past(expB)))
    else $error("fpAlign exponentOut below an input exponent");

endmodule

/* source/Normalize.sv */
// Renormalize and round the sum

`timescale 1ns/1ps
`include "fpadd_settings.svh"

module Normalize (fpBus.normal bus);
    localparam int manW     = `FPADD_MAN_W + 1;
    localparam int extW     = manW + 3;
    localparam int expWideW = `FPADD_EXP_W + 2;

    logic [extW-1:0]            extIn, normExt;
    logic [4:0]                 shiftAmount;
    logic [manW-1:0]            manNorm;
    logic                       guard, round, sticky, roundUp;
    logic [manW:0]              manRounded;
    logic signed [expWideW-1:0] expNorm, expFinal;

    // Leading zeros over mantissa and rounding bits
    function automatic logic [4:0] countZeros(input logic [extW-1:0] value);
        logic [4:0] count;
        logic       found;
        count = '0;
        found = 1'b0;
        for (int i = extW - 1; i >= 0; i--)
        begin
            if (value[i])
                found = 1'b1;
            else if (!found)
                count = count + 5'd1;
        end
        return count;
    endfunction

    always_comb
    begin
        extIn       = {bus.alignedResult, bus.guardBit, bus.roundBit, bus.stickyBit};
        shiftAmount = countZeros(extIn);

        if (bus.carryOut)
        begin
            // Carry out, one place right and the lost bit joins the rounding bits
            normExt = {1'b1, bus.alignedResult, bus.guardBit, bus.roundBit | bus.stickyBit};
            expNorm = $signed({2'b00, bus.exponentOut}) + 10'sd1;
        end
        else
        begin
            normExt = extIn << shiftAmount;
            expNorm = $signed({2'b00, bus.exponentOut}) - $signed({5'b00000, shiftAmount});
        end

        manNorm = normExt[extW-1 -: manW];
        guard   = normExt[2];
        round   = normExt[1];
        sticky  = normExt[0];

        // Nearest even
        roundUp    = guard & (round | sticky | manNorm[0]);
        manRounded = {1'b0, manNorm} + (manW + 1)'(roundUp);
        expFinal   = expNorm + $signed({{(expWideW - 1){1'b0}}, manRounded[manW]});

        bus.normalizedSign = bus.alignedSign;
        if (!bus.carryOut && extIn == '0)
        begin
            // Exact cancellation gives plus zero
            bus.normalizedSign     = 1'b0;
            bus.normalizedExponent = '0;
            bus.normalizedMantissa = '0;
        end
        else if (expNorm < 1)
        begin
            // Underflow flushes to zero, sign kept
            bus.normalizedExponent = '0;
            bus.normalizedMantissa = '0;
        end
        else if (expFinal >= `FPADD_EXP_MAX)
        begin
            bus.normalizedExponent = `FPADD_EXP_W'(`FPADD_EXP_MAX);
            bus.normalizedMantissa = '0;
        end
        else
        begin
            bus.normalizedExponent = expFinal[`FPADD_EXP_W-1:0];
            // Rounding carry leaves an all-zero fraction here
            bus.normalizedMantissa = manRounded[`FPADD_MAN_W-1:0];
        end
    end

endmodule

/* source/fpCtrl.sv */
// Operation and credit controller

`timescale 1ns/1ps

module fpCtrl
    import fpaddPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic opValid,
    output logic opReady,
    input  logic creditAvail,
    output logic alignLoad,
    output logic creditSpend,
    output logic resultValid
);
    ctrlStateE state, stateNext;

    // One operation in flight
    assign opReady     = (state == sIdle);
    assign alignLoad   = opValid && opReady;
    assign resultValid = ((state == sEmit) || (state == sHold)) && creditAvail;
    assign creditSpend = resultValid;

    always_comb
    begin
        stateNext = state;
        case (state)
            sIdle:
            begin
                if (alignLoad)
                    stateNext = sEmit;
            end
            sEmit:
            begin
                stateNext = creditAvail ? sIdle : sHold;
            end
            sHold:
            begin
                // Result waits here for a returned credit
                if (creditAvail)
                    stateNext = sIdle;
            end
            default:
            begin
                stateNext = sIdle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            state <= sIdle;
        else
            state <= stateNext;
    end

    // A result is never issued from idle and always ends the operation
    assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> (state != sIdle) ##1 (state == sIdle))
    else $error("fpCtrl resultValid outside an operation in state %s", state.name());

endmodule

/* source/creditCounter.sv */
// Output credit counter

`timescale 1ns/1ps
`include "fpadd_settings.svh"

module creditCounter (
    input  logic clk,
    input  logic rstN,
    input  logic creditReturn,
    input  logic creditSpend,
    output logic creditAvail
);
    localparam int countW = $clog2(`FPADD_CREDITS + 1);

    logic [countW-1:0] creditCount;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            creditCount <= countW'(`FPADD_CREDITS);
        else if (creditSpend && !creditReturn)
            creditCount <= creditCount - 1'b1;
        else if (creditReturn && !creditSpend)
            creditCount <= creditCount + 1'b1;
    end

    assign creditAvail = (creditCount != '0);

    // Consumer returns no more than it granted
    assert property (@(posedge clk) disable iff (!rstN)
        creditCount <= countW'(`FPADD_CREDITS))
    else $error("creditCounter count above %0d", `FPADD_CREDITS);

    // Controller spends only credits it holds
    assert property (@(posedge clk) disable iff (!rstN)
        creditSpend |-> creditCount != '0)
    else $error("creditCounter spend with no credit");

endmodule

/* source/fpAddTop.sv */
// Floating-point add/subtract unit

`timescale 1ns/1ps
`include "fpadd_settings.svh"

module fpAddTop
    import fpaddPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    opValid,
    output logic                    opReady,
    input  fpOpE                    opCode,
    input  logic [`FPADD_WIDTH-1:0] operandA,
    input  logic [`FPADD_WIDTH-1:0] operandB,
    output logic                    resultValid,
    output logic [`FPADD_WIDTH-1:0] result,
    input  logic                    creditReturn
);
    logic alignLoad;
    logic creditSpend;
    logic creditAvail;

    fpBus busInst ();

    fpCtrl ctrlInst (
        .clk         (clk),
        .rstN        (rstN),
        .opValid     (opValid),
        .opReady     (opReady),
        .creditAvail (creditAvail),
        .alignLoad   (alignLoad),
        .creditSpend (creditSpend),
        .resultValid (resultValid)
    );

    creditCounter creditInst (
        .clk          (clk),
        .rstN         (rstN),
        .creditReturn (creditReturn),
        .creditSpend  (creditSpend),
        .creditAvail  (creditAvail)
    );

    fpAlign alignInst (
        .clk       (clk),
        .rstN      (rstN),
        .alignLoad (alignLoad),
        .opCode    (opCode),
        .operandA  (operandA),
        .operandB  (operandB),
        .bus       (busInst.align)
    );

    Normalize normInst (
        .bus (busInst.normal)
    );

    // Packed binary32 result
    assign result = {busInst.normalizedSign, busInst.normalizedExponent,
                     busInst.normalizedMantissa};

endmodule

/* verif/fpAddTb.sv */
// Floating-point adder testbench

`timescale 1ns/1ps
`include "fpadd_settings.svh"

module fpAddTb
    import fpaddPkg::*;
();
    localparam int randomOps   = 200;
    localparam int directedOps = 2 * `FPADD_CREDITS + 11;
    localparam int stallCycles = (randomOps + 2 * `FPADD_CREDITS) * 4;
    // Twice three cycles per operation plus credit stalls
    localparam int cycleLimit  = 2 * (directedOps + randomOps) * 3 + stallCycles;
    localparam int maxWait     = 16;

    logic                    clk, rstN, opValid, opReady, resultValid, creditReturn;
    fpOpE                    opCode;
    logic [`FPADD_WIDTH-1:0] operandA, operandB, result, expected, lcgState;
    int                      credits, errorCount, cycleCount, opCount, resultCount;

    fpAddTop dut_i (
        .clk          (clk),
        .rstN         (rstN),
        .opValid      (opValid),
        .opReady      (opReady),
        .opCode       (opCode),
        .operandA     (operandA),
        .operandB     (operandB),
        .resultValid  (resultValid),
        .result       (result),
        .creditReturn (creditReturn)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not end within %0d cycles", cycleLimit);
            errorCount++;
            finishRun();
        end
    end

    // Every resultValid cycle counts as one result
    always @(posedge clk)
    begin
        if (rstN && resultValid)
            resultCount++;
    end

    task automatic finishRun();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual, want);
        if (actual !== want)
        begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, actual, want);
            errorCount++;
        end
    endtask

    // Reference sum on 32 extra fraction bits and a sticky LSB
    function automatic logic [31:0] refAdd(input fpOpE op, input logic [31:0] a, b);
        logic [7:0]  eBig, eSmall;
        logic [63:0] mA, mB, mBig, mSmall, r, keep, rem;
        logic        sBig, aBig;
        int          d, p, e;
        mA     = (a[30:23] != 0) ? {40'd0, 1'b1, a[22:0]} << 32 : 64'd0;
        mB     = (b[30:23] != 0) ? {40'd0, 1'b1, b[22:0]} << 32 : 64'd0;
        aBig   = {a[30:23], mA} >= {b[30:23], mB};
        eBig   = aBig ? a[30:23] : b[30:23];
        eSmall = aBig ? b[30:23] : a[30:23];
        mBig   = aBig ? mA : mB;
        mSmall = aBig ? mB : mA;
        sBig   = aBig ? a[31] : b[31] ^ (op == opSub);
        d      = int'(eBig) - int'(eSmall);
        // Smaller operand moves right and lost bits set the LSB
        if (d >= 60)
            r = 64'(mSmall != 0);
        else
            r = (mSmall >> d) | 64'((mSmall & ((64'd1 << d) - 1)) != 0);
        r = (a[31] == (b[31] ^ (op == opSub))) ? mBig + r : mBig - r;
        if (r == 0)
            return '0;
        p = 63;
        while (!r[p])
            p--;
        e = int'(eBig) + p - 55;
        if (e < 1)
            return {sBig, 31'd0};
        keep = r >> (p - 23);
        rem  = r & ((64'd1 << (p - 23)) - 1);
        // Nearest even on everything below the kept 24 bits
        if (rem > (64'd1 << (p - 24)) || (rem == (64'd1 << (p - 24)) && keep[0]))
            keep++;
        if (keep[24])
        begin
            keep = keep >> 1;
            e++;
        end
        if (e >= 255)
            return {sBig, 8'hff, 23'd0};
        return {sBig, 8'(e), keep[22:0]};
    endfunction

    task automatic driveOp(input fpOpE op, input logic [31:0] a, b);
        @(negedge clk);
        creditReturn = 1'b0;
        checkValue("opReady", 32'(opReady), 32'd1);
        opValid  = 1'b1;
        opCode   = op;
        operandA = a;
        operandB = b;
        expected = refAdd(op, a, b);
        opCount++;
        @(negedge clk);
        // New operands after acceptance must not disturb the held result
        opValid  = 1'b0;
        operandA = nextRandom();
        operandB = nextRandom();
    endtask

    // Wait for the result and check it against the model
    task automatic awaitResult(input bit randomReturns);
        int waited;
        waited = 0;
        creditReturn = 1'b0;
        while (!resultValid && waited < maxWait)
        begin
            if (randomReturns && credits < `FPADD_CREDITS &&
                ((credits == 0 && waited >= 2) || nextRandom() < 32'h6000_0000))
            begin
                creditReturn = 1'b1;
                credits++;
            end
            waited++;
            @(negedge clk);
            creditReturn = 1'b0;
        end
        if (!resultValid)
        begin
            $display("No result within %0d cycles of acceptance", maxWait);
            errorCount++;
        end
        else
        begin
            if (credits == 0)
            begin
                $display("resultValid while no credits are held");
                errorCount++;
            end
            credits--;
            checkValue("result", result, expected);
            // Spend and return in the same cycle now and then
            if (randomReturns && nextRandom() >= 32'h8000_0000)
            begin
                creditReturn = 1'b1;
                credits++;
            end
        end
    endtask

    task automatic returnCredits(input int count);
        repeat (count)
        begin
            @(negedge clk);
            creditReturn = 1'b1;
            credits++;
        end
        @(negedge clk);
        creditReturn = 1'b0;
    endtask

    task automatic directedOp(input fpOpE op, input logic [31:0] a, b, known);
        checkValue("refAdd", refAdd(op, a, b), known);
        driveOp(op, a, b);
        awaitResult(1'b0);
        returnCredits(1);
    endtask

    task automatic resetTest();
        checkValue("opReady", 32'(opReady), 32'd1);
        checkValue("resultValid", 32'(resultValid), 32'd0);
        // Back to back with each result one cycle after acceptance
        repeat (`FPADD_CREDITS)
        begin
            driveOp(opAdd, 32'h3f80_0000 + 32'(credits), 32'h4040_0000);
            checkValue("resultValid", 32'(resultValid), 32'd1);
            awaitResult(1'b0);
        end
        returnCredits(`FPADD_CREDITS);
    endtask

    task automatic arithmeticTest();
        directedOp(opAdd, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);
        directedOp(opSub, 32'h3fc0_0000, 32'h3fa0_0000, 32'h3e80_0000);
        directedOp(opSub, 32'h4049_0fdb, 32'h4049_0fdb, 32'h0000_0000);
        directedOp(opAdd, 32'h0000_0000, 32'hc049_0fdb, 32'hc049_0fdb);
        directedOp(opSub, 32'h3f80_0000, 32'h4000_0000, 32'hbf80_0000);
        // Exact ties that stay even or round up to even
        directedOp(opAdd, 32'h3f80_0000, 32'h3380_0000, 32'h3f80_0000);
        directedOp(opAdd, 32'h3f80_0001, 32'h3380_0000, 32'h3f80_0002);
        // Round-up carries into the exponent
        directedOp(opAdd, 32'h3fff_ffff, 32'h3380_0000, 32'h4000_0000);
    endtask

    task automatic specialTest();
        directedOp(opAdd, 32'h7f7f_ffff, 32'h7f7f_ffff, 32'h7f80_0000);
        directedOp(opSub, 32'h8080_0001, 32'h8080_0000, 32'h8000_0000);
    endtask

    task automatic backpressureTest();
        repeat (`FPADD_CREDITS)
        begin
            driveOp(opSub, 32'h4120_0000, 32'h3f80_0000 + 32'(credits));
            awaitResult(1'b0);
        end
        driveOp(opAdd, 32'h3f99_999a, 32'hbe4c_cccd);
        // No credit left so the result waits and no operation is taken
        repeat (3)
        begin
            checkValue("resultValid", 32'(resultValid), 32'd0);
            checkValue("opReady", 32'(opReady), 32'd0);
            @(negedge clk);
        end
        returnCredits(1);
        checkValue("resultValid", 32'(resultValid), 32'd1);
        awaitResult(1'b0);
        returnCredits(`FPADD_CREDITS);
    endtask

    task automatic randomTest();
        logic [31:0] rnd, a, b;
        int          expA, expB;
        repeat (randomOps)
        begin
            rnd  = nextRandom();
            expA = int'(rnd[23:16]) % 254 + 1;
            // Half the pairs get close exponents for cancellation
            expB = rnd[31] ? int'(rnd[15:8]) % 254 + 1 : expA + int'(rnd[26:24]) % 5 - 2;
            if (expB < 1)
                expB = 1;
            if (expB > 254)
                expB = 254;
            rnd = nextRandom();
            a   = {rnd[31], 8'(expA), rnd[22:0]};
            rnd = nextRandom();
            b   = {rnd[31], 8'(expB), rnd[22:0]};
            driveOp(fpOpE'(rnd[30]), a, b);
            awaitResult(1'b1);
        end
        @(negedge clk);
        creditReturn = 1'b0;
        checkValue("resultCount", 32'(resultCount), 32'(opCount));
    endtask

    initial
    begin
        clk          = 1'b0;
        rstN         = 1'b0;
        opValid      = 1'b0;
        opCode       = opAdd;
        operandA     = '0;
        operandB     = '0;
        creditReturn = 1'b0;
        expected     = '0;
        lcgState     = 32'ha4407673;
        credits      = `FPADD_CREDITS;
        errorCount   = 0;
        cycleCount   = 0;
        opCount      = 0;
        resultCount  = 0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        resetTest();
        arithmeticTest();
        specialTest();
        backpressureTest();
        randomTest();
        finishRun();
    end

endmodule

/* fpadd.f */
+incdir+include
source/fpaddPkg.sv
source/fpBus.sv
source/fpAlign.sv
source/Normalize.sv
source/fpCtrl.sv
source/creditCounter.sv
source/fpAddTop.sv
verif/fpAddTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fpAddTb
FILELIST  = fpadd.f
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
